//--- src/field_pkg.sv
// playfield geometry shared by the game RTL, referenced by package-scoped names
`default_nettype none

package field_pkg;

	// obstacle row counter
	localparam int ROW_W = 8;

	// last row before an obstacle wraps back to the top
	localparam int BOTTOM_ROW = 240;

	// fixed row of the player sprite
	localparam int PLAYER_ROW = 190;

	// sprite height, same for player and obstacles
	localparam int SPRITE_H = 50;

	// dice runs 1..ROLL_MAX, one step per clock
	localparam int ROLL_W = 3;
	localparam int ROLL_MAX = 6;

	// this roll leaves the obstacle in its old lane
	localparam int KEEP_ROLL = 5;

endpackage

`default_nettype wire

//--- src/game_pkg.sv
// game-level types (lanes, game states, obstacle records, lane tables) used across the RTL
`default_nettype none

package game_pkg;

	typedef enum logic [1:0] {
		lane_left,
		lane_middle,
		lane_right
	} lane_t;

	typedef enum logic [1:0] {
		st_idle,
		st_play,
		st_over
	} game_state_t;

	// one falling obstacle
	typedef struct packed {
		lane_t                       lane;
		logic [field_pkg::ROW_W-1:0] row;
	} obstacle_t;

	// respawn lane per roll, entry 0 is roll 1
	typedef lane_t [field_pkg::ROLL_MAX-1:0] lane_map_t;

endpackage

`default_nettype wire

//--- src/step_timer.sv
// fall-rate divider; pulses tick once every STEP_CYCLES clocks while the game is in play
`default_nettype none

module step_timer #(
	parameter int STEP_CYCLES = 200000
) (
	input  wire                    clock,
	input  wire                    reset,
	input  game_pkg::game_state_t  state,
	output logic                   tick
);

	localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(STEP_CYCLES - 1);

	logic [CNT_W-1:0] count;
	logic             playing;

	assign playing = (state == game_pkg::st_play);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			count <= RELOAD;
		end else if (!playing) begin
			count <= RELOAD; // restart the period on every entry into play
		end else if (count == '0) begin
			count <= RELOAD;
		end else begin
			count <= count - 1'b1;
		end
	end

	// high in the last cycle of each period, consumed on the closing edge
	assign tick = playing && (count == '0);

	a_tick_single : assert property (@(posedge clock) disable iff (reset)
		tick |=> !tick)
		else $error("tick held high for two cycles");

endmodule

`default_nettype wire

//--- src/lane_control.sv
// player lane register; steps one lane toward a released left/right key during play
`default_nettype none

module lane_control (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    key_left,
	input  wire                    key_right,
	input  game_pkg::game_state_t  state,
	output game_pkg::lane_t        lane
);

	logic key_left_q;
	logic key_right_q;
	logic rel_left;
	logic rel_right;

	// previous key levels, sampled in every state
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			key_left_q  <= 1'b0;
			key_right_q <= 1'b0;
		end else begin
			key_left_q  <= key_left;
			key_right_q <= key_right;
		end
	end

	assign rel_left  = key_left_q && !key_left;
	assign rel_right = key_right_q && !key_right;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lane <= game_pkg::lane_middle;
		end else if (state == game_pkg::st_idle) begin
			lane <= game_pkg::lane_middle;
		end else if (state == game_pkg::st_play) begin
			if (rel_left) begin // left wins a joint release
				case (lane)
					game_pkg::lane_right:  lane <= game_pkg::lane_middle;
					default:               lane <= game_pkg::lane_left;
				endcase
			end else if (rel_right) begin
				case (lane)
					game_pkg::lane_left:   lane <= game_pkg::lane_middle;
					default:               lane <= game_pkg::lane_right;
				endcase
			end
		end
	end

	a_lane_legal : assert property (@(posedge clock) disable iff (reset)
		!$isunknown(lane) && (lane inside {game_pkg::lane_left, game_pkg::lane_middle,
			game_pkg::lane_right}))
		else $error("lane left the legal encodings: %b", lane);

endmodule

`default_nettype wire

//--- src/obstacle_unit.sv
// one falling obstacle with its own dice; respawns at the top in a lane picked from LANE_MAP
`default_nettype none

module obstacle_unit #(
	parameter game_pkg::lane_map_t           LANE_MAP  = '{default: game_pkg::lane_middle},
	parameter logic [field_pkg::ROW_W-1:0]   START_ROW = '0
) (
	input  wire                    clock,
	input  wire                    reset,
	input  game_pkg::game_state_t  state,
	input  wire                    tick,
	output game_pkg::obstacle_t    obst
);

	localparam logic [field_pkg::ROLL_W-1:0] ROLL_FIRST = 1;

	logic [field_pkg::ROLL_W-1:0] roll;
	game_pkg::lane_t              next_lane;

	// free-running dice, 1..ROLL_MAX
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			roll <= ROLL_FIRST;
		end else if (roll == field_pkg::ROLL_MAX) begin
			roll <= ROLL_FIRST;
		end else begin
			roll <= roll + 1'b1;
		end
	end

	always_comb begin
		if (roll == field_pkg::KEEP_ROLL) begin
			next_lane = obst.lane;
		end else begin
			next_lane = LANE_MAP[roll - ROLL_FIRST];
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			obst.row  <= START_ROW;
			obst.lane <= game_pkg::lane_middle;
		end else begin
			case (state)
				game_pkg::st_idle: begin
					obst.row  <= START_ROW;
					obst.lane <= game_pkg::lane_middle;
				end
				game_pkg::st_play: begin
					if (tick) begin
						if (obst.row == field_pkg::BOTTOM_ROW) begin
							obst.row  <= '0; // back to the top
							obst.lane <= next_lane;
						end else begin
							obst.row <= obst.row + 1'b1;
						end
					end
				end
				default: ; // frozen after a hit
			endcase
		end
	end

	a_row_range : assert property (@(posedge clock) disable iff (reset)
		obst.row <= field_pkg::BOTTOM_ROW)
		else $error("obstacle row %0d past bottom", obst.row);

endmodule

`default_nettype wire

//--- src/game_fsm.sv
// idle/play/over game sequencer; ends play when an obstacle overlaps the player
`default_nettype none

module game_fsm (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    key_start,
	input  game_pkg::lane_t        lane,
	input  game_pkg::obstacle_t    obst0,
	input  game_pkg::obstacle_t    obst1,
	output game_pkg::game_state_t  state
);

	game_pkg::game_state_t next_state;
	logic                  hit;

	// same lane and vertical spans overlap
	function automatic logic overlap(input game_pkg::obstacle_t o, input game_pkg::lane_t l);
		logic same_lane;
		logic below_top;
		logic above_bottom;
		same_lane    = (o.lane == l);
		below_top    = (int'(o.row) + field_pkg::SPRITE_H) > field_pkg::PLAYER_ROW;
		above_bottom = int'(o.row) < (field_pkg::PLAYER_ROW + field_pkg::SPRITE_H);
		return same_lane && below_top && above_bottom;
	endfunction

	assign hit = overlap(obst0, lane) || overlap(obst1, lane);

	always_comb begin
		next_state = state;
		case (state)
			game_pkg::st_idle: begin
				if (key_start) begin
					next_state = game_pkg::st_play;
				end
			end
			game_pkg::st_play: begin
				if (hit) begin
					next_state = game_pkg::st_over;
				end
			end
			game_pkg::st_over: begin
				if (key_start) begin
					next_state = game_pkg::st_idle;
				end
			end
			default: next_state = game_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= game_pkg::st_idle;
		end else begin
			state <= next_state;
		end
	end

	a_over_from_play : assert property (@(posedge clock) disable iff (reset)
		$rose(state == game_pkg::st_over) |-> $past(state) == game_pkg::st_play)
		else $error("game over entered from a state other than play");

endmodule

`default_nettype wire

//--- src/dodge_game.sv
// lane-dodging game core: connects sequencer, fall timer, player lane and two obstacles
`default_nettype none

module dodge_game #(
	parameter int                          STEP_CYCLES = 200000,
	parameter game_pkg::lane_map_t         LANE_MAP0   = '{game_pkg::lane_right,
		game_pkg::lane_middle, game_pkg::lane_left, game_pkg::lane_middle,
		game_pkg::lane_right, game_pkg::lane_left},
	parameter game_pkg::lane_map_t         LANE_MAP1   = '{game_pkg::lane_left,
		game_pkg::lane_middle, game_pkg::lane_right, game_pkg::lane_left,
		game_pkg::lane_middle, game_pkg::lane_right},
	parameter logic [field_pkg::ROW_W-1:0] START_ROW0  = 0,
	parameter logic [field_pkg::ROW_W-1:0] START_ROW1  = 120 // keeps the pair apart
) (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    key_left,
	input  wire                    key_right,
	input  wire                    key_start,
	output game_pkg::game_state_t  state,
	output game_pkg::lane_t        lane,
	output game_pkg::obstacle_t    obst0,
	output game_pkg::obstacle_t    obst1
);

	logic tick; // shared fall step

	game_fsm game_fsm_inst (
		.clock     (clock),
		.reset     (reset),
		.key_start (key_start),
		.lane      (lane),
		.obst0     (obst0),
		.obst1     (obst1),
		.state     (state)
	);

	step_timer #(
		.STEP_CYCLES (STEP_CYCLES)
	) step_timer_inst (
		.clock (clock),
		.reset (reset),
		.state (state),
		.tick  (tick)
	);

	lane_control lane_control_inst (
		.clock     (clock),
		.reset     (reset),
		.key_left  (key_left),
		.key_right (key_right),
		.state     (state),
		.lane      (lane)
	);

	obstacle_unit #(
		.LANE_MAP  (LANE_MAP0),
		.START_ROW (START_ROW0)
	) obstacle0 (
		.clock (clock),
		.reset (reset),
		.state (state),
		.tick  (tick),
		.obst  (obst0)
	);

	obstacle_unit #(
		.LANE_MAP  (LANE_MAP1),
		.START_ROW (START_ROW1)
	) obstacle1 (
		.clock (clock),
		.reset (reset),
		.state (state),
		.tick  (tick),
		.obst  (obst1)
	);

endmodule

`default_nettype wire

//--- tb/tb_dodge_game.sv
// testbench for dodge_game: LFSR and steered key stimulus, reference model, concurrent checks
`default_nettype none

module tb_dodge_game;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int STEP_CYCLES = 4;
	localparam int RESET_CYCLES = 16;
	localparam int DODGE_CYCLES = 1000; // long enough for both obstacles to wrap once
	// three rounds of about 250 fall steps, doubled for slack
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 3 * 250 * STEP_CYCLES);
	localparam logic [field_pkg::ROW_W-1:0] START_ROW0 = 0;
	localparam logic [field_pkg::ROW_W-1:0] START_ROW1 = 120;

	// rightmost entry is roll 1
	localparam game_pkg::lane_map_t LANE_MAP0 = '{game_pkg::lane_right, game_pkg::lane_left,
		game_pkg::lane_right, game_pkg::lane_middle, game_pkg::lane_right, game_pkg::lane_left};
	localparam game_pkg::lane_map_t LANE_MAP1 = '{game_pkg::lane_left, game_pkg::lane_right,
		game_pkg::lane_left, game_pkg::lane_middle, game_pkg::lane_left, game_pkg::lane_right};

	logic                  clock;
	logic                  reset;
	logic                  key_left;
	logic                  key_right;
	logic                  key_start;
	game_pkg::game_state_t state;
	game_pkg::lane_t       lane;
	game_pkg::obstacle_t   obst0;
	game_pkg::obstacle_t   obst1;

	logic [15:0] lfsr;
	int          cycle_count = 0;

	// reference model
	game_pkg::game_state_t m_state;
	game_pkg::lane_t       m_lane;
	game_pkg::obstacle_t   m_obst0;
	game_pkg::obstacle_t   m_obst1;
	int                    m_roll;
	int                    m_count;
	logic                  m_tick;
	logic                  m_hit;
	logic                  m_left_q;
	logic                  m_right_q;

	dodge_game #(
		.STEP_CYCLES (STEP_CYCLES),
		.LANE_MAP0   (LANE_MAP0),
		.LANE_MAP1   (LANE_MAP1),
		.START_ROW0  (START_ROW0),
		.START_ROW1  (START_ROW1)
	) dodge_game_inst (
		.clock     (clock),
		.reset     (reset),
		.key_left  (key_left),
		.key_right (key_right),
		.key_start (key_start),
		.state     (state),
		.lane      (lane),
		.obst0     (obst0),
		.obst1     (obst1)
	);

	always #50 clock = ~clock;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic model_hit(input game_pkg::obstacle_t o, input game_pkg::lane_t l);
		int top;
		top = int'(o.row);
		return (o.lane == l) && (top + field_pkg::SPRITE_H > field_pkg::PLAYER_ROW)
			&& (top < field_pkg::PLAYER_ROW + field_pkg::SPRITE_H);
	endfunction

	function automatic game_pkg::lane_t moved_lane(input game_pkg::lane_t l, input logic rel_l,
		input logic rel_r);
		if (rel_l)
			return (l == game_pkg::lane_right) ? game_pkg::lane_middle : game_pkg::lane_left;
		if (rel_r)
			return (l == game_pkg::lane_left) ? game_pkg::lane_middle : game_pkg::lane_right;
		return l;
	endfunction

	function automatic game_pkg::obstacle_t fall(input game_pkg::obstacle_t o,
		input game_pkg::lane_map_t lane_table, input int roll);
		game_pkg::obstacle_t n;
		n = o;
		if (int'(o.row) == field_pkg::BOTTOM_ROW) begin
			n.row = '0;
			if (roll != field_pkg::KEEP_ROLL)
				n.lane = lane_table[roll - 1];
		end else begin
			n.row = o.row + 1'b1;
		end
		return n;
	endfunction

	assign m_tick = (m_state == game_pkg::st_play) && (m_count == STEP_CYCLES - 1);
	assign m_hit = model_hit(m_obst0, m_lane) || model_hit(m_obst1, m_lane);

	always @(posedge clock or posedge reset) begin
		if (reset) begin
			m_state <= game_pkg::st_idle;
			m_lane <= game_pkg::lane_middle;
			m_obst0.lane <= game_pkg::lane_middle;
			m_obst0.row <= START_ROW0;
			m_obst1.lane <= game_pkg::lane_middle;
			m_obst1.row <= START_ROW1;
			m_roll <= 1;
			m_count <= 0;
			m_left_q <= 1'b0;
			m_right_q <= 1'b0;
		end else begin
			m_roll <= (m_roll == field_pkg::ROLL_MAX) ? 1 : m_roll + 1;
			m_left_q <= key_left;
			m_right_q <= key_right;
			m_count <= (m_state == game_pkg::st_play && !m_tick) ? m_count + 1 : 0;
			case (m_state)
				game_pkg::st_idle: begin
					m_lane <= game_pkg::lane_middle;
					m_obst0.lane <= game_pkg::lane_middle;
					m_obst0.row <= START_ROW0;
					m_obst1.lane <= game_pkg::lane_middle;
					m_obst1.row <= START_ROW1;
					if (key_start)
						m_state <= game_pkg::st_play;
				end
				game_pkg::st_play: begin
					m_lane <= moved_lane(m_lane, m_left_q && !key_left, m_right_q && !key_right);
					if (m_tick) begin
						m_obst0 <= fall(m_obst0, LANE_MAP0, m_roll);
						m_obst1 <= fall(m_obst1, LANE_MAP1, m_roll);
					end
					if (m_hit)
						m_state <= game_pkg::st_over;
				end
				default: if (key_start) m_state <= game_pkg::st_idle; // everything frozen
			endcase
		end
	end

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic mismatch(input string name, input int got, input int exp);
		$display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		stop_run();
	endtask

	a_state : assert property (@(posedge clock) disable iff (reset) state == m_state)
		else mismatch("state", $sampled(state), $sampled(m_state));
	a_lane : assert property (@(posedge clock) disable iff (reset) lane == m_lane)
		else mismatch("lane", $sampled(lane), $sampled(m_lane));
	a_row0 : assert property (@(posedge clock) disable iff (reset) obst0.row == m_obst0.row)
		else mismatch("obst0.row", $sampled(obst0.row), $sampled(m_obst0.row));
	a_lane0 : assert property (@(posedge clock) disable iff (reset) obst0.lane == m_obst0.lane)
		else mismatch("obst0.lane", $sampled(obst0.lane), $sampled(m_obst0.lane));
	a_row1 : assert property (@(posedge clock) disable iff (reset) obst1.row == m_obst1.row)
		else mismatch("obst1.row", $sampled(obst1.row), $sampled(m_obst1.row));
	a_lane1 : assert property (@(posedge clock) disable iff (reset) obst1.lane == m_obst1.lane)
		else mismatch("obst1.lane", $sampled(obst1.lane), $sampled(m_obst1.lane));
	a_tick : assert property (@(posedge clock) disable iff (reset)
		dodge_game_inst.tick == m_tick)
		else mismatch("tick", $sampled(dodge_game_inst.tick), $sampled(m_tick));

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: the game was still running after %0d cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	task automatic drive_cycle(input logic l, input logic r, input logic s);
		@(posedge clock);
		#5;
		key_left = l;
		key_right = r;
		key_start = s;
	endtask

	task automatic take_bit(output logic b);
		lfsr = lfsr_step(lfsr);
		b = lfsr[0];
	endtask

	task automatic random_keys();
		logic l;
		logic r;
		take_bit(l);
		take_bit(r);
		drive_cycle(l, r, 1'b0);
	endtask

	task automatic tap(input logic l, input logic r);
		drive_cycle(l, r, 1'b0);
		drive_cycle(1'b0, 1'b0, 1'b0); // release moves the lane
	endtask

	function automatic logic lane_busy(input game_pkg::lane_t l, input int lo);
		return (obst0.lane == l && int'(obst0.row) >= lo)
			|| (obst1.lane == l && int'(obst1.row) >= lo);
	endfunction

	function automatic int zone_distance(input game_pkg::obstacle_t o);
		int first;
		first = field_pkg::PLAYER_ROW - field_pkg::SPRITE_H + 1;
		if (model_hit(o, o.lane))
			return 0;
		if (int'(o.row) < first)
			return first - int'(o.row);
		return first + 1; // at the bottom, about to wrap
	endfunction

	// press on one cycle, release on the next
	task automatic steer_cycle(input game_pkg::lane_t target);
		logic l;
		logic r;
		l = 1'b0;
		r = 1'b0;
		if (!key_left && !key_right) begin
			r = (lane < target);
			l = (lane > target);
		end
		drive_cycle(l, r, 1'b0);
	endtask

	task automatic dodge_cycle();
		game_pkg::lane_t target;
		game_pkg::lane_t next;
		target = lane;
		if (lane_busy(lane, 100)) begin
			if (lane != game_pkg::lane_left && !lane_busy(game_pkg::lane_t'(lane - 1), 100))
				target = game_pkg::lane_t'(lane - 1);
			else if (lane != game_pkg::lane_right && !lane_busy(game_pkg::lane_t'(lane + 1), 100))
				target = game_pkg::lane_t'(lane + 1);
			else
				target = (lane == game_pkg::lane_left) ? game_pkg::lane_right : game_pkg::lane_left;
			next = (target > lane) ? game_pkg::lane_t'(lane + 1) : game_pkg::lane_t'(lane - 1);
			if (lane_busy(next, 125))
				target = lane; // wait for the crossing lane to clear
		end
		steer_cycle(target);
	endtask

	task automatic dodge_for(input int cycles);
		for (int i = 0; i < cycles && state == game_pkg::st_play; i++)
			dodge_cycle();
	endtask

	// run into the obstacle closest to the player row, then watch the frozen field
	task automatic finish_round();
		while (state == game_pkg::st_play)
			steer_cycle((zone_distance(obst0) <= zone_distance(obst1)) ? obst0.lane : obst1.lane);
		repeat (8) drive_cycle(1'b0, 1'b0, 1'b0);
	endtask

	task automatic start_at_roll(input int r);
		while (m_roll != r)
			drive_cycle(1'b0, 1'b0, 1'b0);
		key_start = 1'b1;
		drive_cycle(1'b0, 1'b0, 1'b0);
		while (state != game_pkg::st_play)
			drive_cycle(1'b0, 1'b0, 1'b0);
	endtask

	task automatic restart();
		key_start = 1'b1;
		drive_cycle(1'b0, 1'b0, 1'b0);
		while (state != game_pkg::st_idle)
			drive_cycle(1'b0, 1'b0, 1'b0);
		repeat (6) random_keys();
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		key_left = 1'b0;
		key_right = 1'b0;
		key_start = 1'b0;
		lfsr = 16'd69;
		repeat (RESET_CYCLES) @(posedge clock);
		#5;
		reset = 1'b0;

		repeat (20) random_keys(); // idle ignores the lane keys

		// round 1: directed moves, random play, then a hit
		start_at_roll(2);
		tap(1'b1, 1'b1); // joint release, left wins
		tap(1'b1, 1'b0);
		repeat (3) tap(1'b0, 1'b1);
		for (int i = 0; i < 200 && state == game_pkg::st_play; i++)
			random_keys();
		finish_round();

		// round 2: both wraps land on the keep roll
		restart();
		start_at_roll(1);
		dodge_for(DODGE_CYCLES);
		finish_round();

		// round 3: both wraps take table entry 0
		restart();
		start_at_roll(3);
		dodge_for(DODGE_CYCLES);
		finish_round();

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
src/field_pkg.sv
src/game_pkg.sv
src/step_timer.sv
src/lane_control.sv
src/obstacle_unit.sv
src/game_fsm.sv
src/dodge_game.sv
tb/tb_dodge_game.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_dodge_game
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# a failing check ends in $fatal, so the simulator's exit status fails the target
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
